// File: cpuPkg.sv
package cpuPkg;

    // ==============================
    // Data widths
    // ==============================
    typedef logic [7:0]  byteT;        // Memory data byte
    typedef logic [7:0]  addressT;     // Memory byte address
    typedef logic [15:0] instructionT; // Two fetched bytes
    typedef logic [31:0] wordT;        // DR and R1 to R4
    typedef logic [1:0]  regSelT;      // Picks R1 to R4
    typedef logic [3:0]  regEnableT;   // One-hot register write enable
    typedef logic [11:0] stepT;        // One-hot timing step
    typedef logic [1:0]  byteLaneT;    // Byte of Rx sent on a store

    // Only the kept memory instructions carry a name
    typedef enum logic [5:0] {
        opLdal = 6'h1E,
        opLdah = 6'h1F,
        opSta  = 6'h20
    } opcodeT;

    typedef enum logic {
        addrPc = 1'b0,
        addrAr = 1'b1
    } addrSourceT;

    // ==============================
    // Timing steps
    // ==============================
    localparam stepT stepT0  = 12'b0000_0000_0001;
    localparam stepT stepT1  = 12'b0000_0000_0010;
    localparam stepT stepT2  = 12'b0000_0000_0100;
    localparam stepT stepT3  = 12'b0000_0000_1000;
    localparam stepT stepT4  = 12'b0000_0001_0000;
    localparam stepT stepT5  = 12'b0000_0010_0000;
    localparam stepT stepT6  = 12'b0000_0100_0000;
    localparam stepT stepT7  = 12'b0000_1000_0000;
    localparam stepT stepT8  = 12'b0001_0000_0000;
    localparam stepT stepT9  = 12'b0010_0000_0000;
    localparam stepT stepT10 = 12'b0100_0000_0000;
    localparam stepT stepT11 = 12'b1000_0000_0000;

    // ==============================
    // Instruction fields
    // ==============================
    localparam int opcodeHigh = 15;
    localparam int opcodeLow  = 10;
    localparam int regSelHigh = 9;
    localparam int regSelLow  = 8;
    // Address field sits in the low byte

    localparam addressT pcResetValue = 8'h00;

endpackage

// File: controlBus.sv
`timescale 1ns/1ps

interface controlBus import cpuPkg::*; ();

    logic       pcIncrement;  // Step PC
    logic       arLoad;       // AR takes the address field
    logic       arIncrement;  // Step AR
    addrSourceT addrSource;   // PC or AR onto the memory address
    logic       drLoadByte;   // DR takes memory byte, zero-extended
    logic       drShiftByte;  // DR shifts left and takes byte in low lane
    regEnableT  rfLoad;       // Register write enable from DR
    byteLaneT   storeLane;    // Rx byte lane written to memory

    modport control (
        output pcIncrement, arLoad, arIncrement, addrSource,
        output drLoadByte, drShiftByte, rfLoad, storeLane
    );

    modport address (
        input pcIncrement, arLoad, arIncrement, addrSource
    );

    modport data (
        input drLoadByte, drShiftByte, rfLoad, storeLane
    );

endinterface

// File: instructionRegister.sv
`timescale 1ns/1ps

module instructionRegister import cpuPkg::*; (
    input  logic    Clock,
    input  logic    Reset,
    input  byteT    memReadData,
    input  logic    irLoadLow,
    input  logic    irLoadHigh,
    output opcodeT  opcode,
    output regSelT  regSel,
    output addressT addressField
);

    byteT        lowByte;
    byteT        highByte;
    instructionT instruction;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            lowByte  <= '0;
            highByte <= '0;
        end else begin
            if (irLoadLow) lowByte <= memReadData;    // First fetch byte
            if (irLoadHigh) highByte <= memReadData;  // Second fetch byte
        end
    end

    assign instruction  = {highByte, lowByte};
    assign opcode       = opcodeT'(instruction[opcodeHigh:opcodeLow]);
    assign regSel       = instruction[regSelHigh:regSelLow];
    assign addressField = instruction[$bits(addressT)-1:0];

    // Both halves come from a single memory read port
    irLoadExclusive: assert property (@(posedge Clock) disable iff (Reset)
        !(irLoadLow && irLoadHigh))
        else $error("IR low and high loads asserted together");

endmodule

// File: controlUnit.sv
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  logic   Clock,
    input  logic   Reset,
    input  opcodeT opcode,
    input  regSelT regSel,
    controlBus.control bus,
    output logic   irLoadLow,
    output logic   irLoadHigh,
    output logic   memWrite,
    output logic   memEnable,
    output stepT   step
);

    logic      endStep;     // Instruction finishes in this step
    regEnableT loadEnable;  // Decoded Rx write enable

    // ==============================
    // Timing counter
    // ==============================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            step <= stepT0;
        end else if (endStep) begin
            step <= stepT0;
        end else begin
            step <= {step[$bits(stepT)-2:0], step[$bits(stepT)-1]};  // Rotate
        end
    end

    assign loadEnable = regEnableT'(1) << regSel;

    // ==============================
    // Control word
    // ==============================
    always_comb begin
        bus.pcIncrement = 1'b0;
        bus.arLoad      = 1'b0;
        bus.arIncrement = 1'b0;
        bus.addrSource  = addrPc;
        bus.drLoadByte  = 1'b0;
        bus.drShiftByte = 1'b0;
        bus.rfLoad      = '0;
        bus.storeLane   = '0;
        irLoadLow       = 1'b0;
        irLoadHigh      = 1'b0;
        memWrite        = 1'b0;
        memEnable       = 1'b0;
        endStep         = 1'b0;

        case (step)
            stepT0: begin
                memEnable       = 1'b1;  // Read mem[PC]
                irLoadLow       = 1'b1;
                bus.pcIncrement = 1'b1;
            end
            stepT1: begin
                memEnable  = 1'b1;
                irLoadHigh = 1'b1;
            end
            stepT2: bus.pcIncrement = 1'b1;  // Point past the instruction
            stepT3: begin
                case (opcode)
                    opLdal, opLdah, opSta: bus.arLoad = 1'b1;
                    default: endStep = 1'b1;  // No-op
                endcase
            end
            stepT4, stepT5, stepT6, stepT7: begin
                bus.addrSource = addrAr;
                case (opcode)
                    opLdal: begin
                        if (step == stepT6) begin
                            bus.rfLoad = loadEnable;
                            endStep    = 1'b1;
                        end else begin
                            memEnable       = 1'b1;
                            bus.drLoadByte  = (step == stepT4);
                            bus.drShiftByte = (step == stepT5);
                            bus.arIncrement = (step == stepT4);
                        end
                    end
                    opLdah: begin
                        memEnable       = 1'b1;
                        bus.drLoadByte  = (step == stepT4);  // MSB arrives first
                        bus.drShiftByte = (step != stepT4);
                        bus.arIncrement = (step != stepT7);
                    end
                    opSta: begin
                        memEnable = 1'b1;
                        memWrite  = 1'b1;
                        // Lane follows the step, LSB first
                        case (step)
                            stepT4:  bus.storeLane = 2'd0;
                            stepT5:  bus.storeLane = 2'd1;
                            stepT6:  bus.storeLane = 2'd2;
                            default: bus.storeLane = 2'd3;
                        endcase
                        bus.arIncrement = (step != stepT7);
                        endStep         = (step == stepT7);
                    end
                    default: endStep = 1'b1;
                endcase
            end
            stepT8: begin
                bus.rfLoad = loadEnable;  // Only LDAH lives this long
                endStep    = 1'b1;
            end
            stepT9, stepT10, stepT11: endStep = 1'b0;  // Never reached, wraps by rotation
            default: endStep = 1'b1;
        endcase
    end

    stepOneHot: assert property (@(posedge Clock) disable iff (Reset)
        $onehot(step))
        else $error("Timing step not one-hot");

    writeNeedsEnable: assert property (@(posedge Clock) disable iff (Reset)
        memWrite |-> memEnable)
        else $error("Memory write without enable");

endmodule

// File: addressUnit.sv
`timescale 1ns/1ps

module addressUnit import cpuPkg::*; (
    input  logic    Clock,
    input  logic    Reset,
    controlBus.address bus,
    input  addressT addressField,
    output addressT memAddress
);

    addressT pc;
    addressT ar;

    // ==============================
    // PC and AR
    // ==============================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= pcResetValue;
        end else if (bus.pcIncrement) begin
            pc <= pc + 8'd1;
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            ar <= '0;
        end else if (bus.arLoad) begin
            ar <= addressField;  // Operand address from IR
        end else if (bus.arIncrement) begin
            ar <= ar + 8'd1;     // Next byte of the operand
        end
    end

    assign memAddress = (bus.addrSource == addrAr) ? ar : pc;

    arLoadOrIncrement: assert property (@(posedge Clock) disable iff (Reset)
        !(bus.arLoad && bus.arIncrement))
        else $error("AR load and increment requested together");

endmodule

// File: dataUnit.sv
`timescale 1ns/1ps

module dataUnit import cpuPkg::*; (
    input  logic   Clock,
    input  logic   Reset,
    controlBus.data bus,
    input  byteT   memReadData,
    input  regSelT regSel,
    output byteT   memWriteData
);

    wordT dr;
    wordT regFile [4];  // R1 to R4
    wordT storeWord;

    // ==============================
    // Data register
    // ==============================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dr <= '0;
        end else if (bus.drLoadByte) begin
            dr <= wordT'(memReadData);  // Zero-extend
        end else if (bus.drShiftByte) begin
            dr <= {dr[$bits(wordT)-$bits(byteT)-1:0], memReadData};
        end
    end

    // ==============================
    // General registers
    // ==============================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < 4; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (bus.rfLoad[i]) regFile[i] <= dr;
            end
        end
    end

    // Store path picks one byte of Rx
    assign storeWord    = regFile[regSel];
    assign memWriteData = storeWord[{bus.storeLane, 3'b000} +: $bits(byteT)];

    rfLoadOneHot: assert property (@(posedge Clock) disable iff (Reset)
        $onehot0(bus.rfLoad))
        else $error("More than one register write enable");

endmodule

// File: cpuSystem.sv
`timescale 1ns/1ps

module cpuSystem import cpuPkg::*; (
    input  logic    Clock,
    input  logic    Reset,
    input  byteT    memReadData,
    output addressT memAddress,
    output byteT    memWriteData,
    output logic    memWrite,
    output logic    memEnable,
    output stepT    step
);

    opcodeT  opcode;
    regSelT  regSel;
    addressT addressField;
    logic    irLoadLow;
    logic    irLoadHigh;

    controlBus bus ();

    instructionRegister instructionRegister_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .memReadData  (memReadData),
        .irLoadLow    (irLoadLow),
        .irLoadHigh   (irLoadHigh),
        .opcode       (opcode),
        .regSel       (regSel),
        .addressField (addressField)
    );

    controlUnit controlUnit_i (
        .Clock      (Clock),
        .Reset      (Reset),
        .opcode     (opcode),
        .regSel     (regSel),
        .bus        (bus.control),
        .irLoadLow  (irLoadLow),
        .irLoadHigh (irLoadHigh),
        .memWrite   (memWrite),
        .memEnable  (memEnable),
        .step       (step)
    );

    addressUnit addressUnit_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .bus          (bus.address),
        .addressField (addressField),
        .memAddress   (memAddress)
    );

    dataUnit dataUnit_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .bus          (bus.data),
        .memReadData  (memReadData),
        .regSel       (regSel),
        .memWriteData (memWriteData)
    );

endmodule

// File: tbCpuSystem.sv
`timescale 1ns/1ps

module tbCpuSystem import cpuPkg::*; ();

    typedef struct packed {
        logic [5:0] op;
        regSelT     rsel;
        addressT    addr;
        logic [7:0] cycles;  // Expected length, T0 back to T0
    } rowT;

    typedef struct packed {
        addressT addr;
        byteT    value;
    } dataRowT;

    localparam int progLen = 8;
    localparam int dataLen = 8;

    logic    Clock;
    logic    Reset;
    byteT    memReadData;
    addressT memAddress;
    byteT    memWriteData;
    logic    memWrite;
    logic    memEnable;
    stepT    step;

    rowT     progTable [progLen];
    dataRowT dataTable [dataLen];
    byteT    initImage [256];
    byteT    mem [256];
    byteT    expMem [256];
    wordT    modelReg [4];  // R1 to R4 as the load rules predict
    addressT expPc;
    int      cycleCount = 0;
    int      timeoutLimit = 1000;

    cpuSystem cpuSystem_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .memReadData  (memReadData),
        .memAddress   (memAddress),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memEnable    (memEnable),
        .step         (step)
    );

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    // ==============================
    // Memory model
    // ==============================
    assign memReadData = mem[memAddress];  // Combinational read

    always @(posedge Clock) begin
        if (Reset) begin
            mem <= initImage;  // Image loaded while held in reset
        end else if (memEnable && memWrite) begin
            mem[memAddress] <= memWriteData;
        end
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            stopWithFailure($sformatf("Timeout: the program did not finish within %0d clock cycles",
                timeoutLimit));
        end
    end

    task automatic stopWithFailure(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic loadTables();
        progTable[0] = '{opLdal, 2'd0, 8'h80, 8'd7};
        progTable[1] = '{opSta,  2'd0, 8'hA0, 8'd8};
        progTable[2] = '{opLdah, 2'd1, 8'h84, 8'd9};
        progTable[3] = '{opSta,  2'd1, 8'hA4, 8'd8};
        progTable[4] = '{6'h05,  2'd2, 8'h90, 8'd4};  // Unnamed opcode
        progTable[5] = '{opLdal, 2'd3, 8'h88, 8'd7};
        progTable[6] = '{opSta,  2'd3, 8'hA8, 8'd8};
        progTable[7] = '{6'h3F,  2'd0, 8'hA0, 8'd4};  // Would hit R1's store area
        dataTable[0] = '{8'h80, 8'h12};
        dataTable[1] = '{8'h81, 8'h34};
        dataTable[2] = '{8'h84, 8'hDE};
        dataTable[3] = '{8'h85, 8'hAD};
        dataTable[4] = '{8'h86, 8'hBE};
        dataTable[5] = '{8'h87, 8'hEF};
        dataTable[6] = '{8'h88, 8'h9A};
        dataTable[7] = '{8'h89, 8'h5C};
    endtask

    // Address field in the first byte, opcode and Rx in the second
    task automatic buildImage();
        for (int a = 0; a < 256; a++) begin
            initImage[a] = addressT'(a) ^ 8'hA5;
        end
        for (int i = 0; i < progLen; i++) begin
            initImage[2 * i]     = progTable[i].addr;
            initImage[2 * i + 1] = {progTable[i].op, progTable[i].rsel};
        end
        for (int i = 0; i < dataLen; i++) begin
            initImage[dataTable[i].addr] = dataTable[i].value;
        end
        expMem = initImage;
    endtask

    // ==============================
    // One instruction, sampled at falling edges
    // ==============================
    task automatic runInstruction(input rowT row);
        logic [7:0] cycles;
        int         writes;
        byteT       storeByte;
        cycles = 8'd0;
        writes = 0;
        do begin
            assert ($onehot(step)) else stopWithFailure(
                $sformatf("ERR @%0t: step %b is not one-hot", $time, step));
            if (cycles == 8'd0) begin
                assert (step == stepT0 && memAddress == expPc && memEnable) else stopWithFailure(
                    $sformatf("ERR @%0t: T0 fetch step %b address %h, expected PC %h",
                        $time, step, memAddress, expPc));
            end
            if (cycles == 8'd1) begin
                assert (step == stepT1 && memAddress == expPc + 8'd1) else stopWithFailure(
                    $sformatf("ERR @%0t: T1 fetch step %b address %h, expected %h",
                        $time, step, memAddress, expPc + 8'd1));
            end
            if (memWrite) begin
                assert (row.op == opSta && writes < 4) else stopWithFailure(
                    $sformatf("ERR @%0t: write to %h by opcode %h", $time, memAddress, row.op));
                storeByte = byteT'(modelReg[row.rsel] >> (8 * writes));  // LSB first
                assert (memAddress == row.addr + addressT'(writes)) else stopWithFailure(
                    $sformatf("ERR @%0t: write address %h, expected %h",
                        $time, memAddress, row.addr + addressT'(writes)));
                assert (memWriteData == storeByte) else stopWithFailure(
                    $sformatf("ERR @%0t: write data %h, expected %h",
                        $time, memWriteData, storeByte));
                expMem[row.addr + addressT'(writes)] = storeByte;
                writes++;
            end
            cycles++;
            @(negedge Clock);
        end while (step != stepT0);

        assert (cycles == row.cycles) else stopWithFailure(
            $sformatf("ERR @%0t: opcode %h took %0d cycles, expected %0d",
                $time, row.op, cycles, row.cycles));
        assert (writes == ((row.op == opSta) ? 4 : 0)) else stopWithFailure(
            $sformatf("ERR @%0t: opcode %h made %0d writes", $time, row.op, writes));

        expPc = expPc + 8'd2;
        if (row.op == opLdal) begin
            modelReg[row.rsel] = {16'h0000, expMem[row.addr], expMem[row.addr + 8'd1]};
        end else if (row.op == opLdah) begin
            modelReg[row.rsel] = {expMem[row.addr], expMem[row.addr + 8'd1],
                                  expMem[row.addr + 8'd2], expMem[row.addr + 8'd3]};
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        Reset = 1'b1;
        loadTables();
        buildImage();
        timeoutLimit = 20;
        for (int i = 0; i < progLen; i++) begin
            timeoutLimit += int'(progTable[i].cycles);
        end
        for (int i = 0; i < 4; i++) begin
            modelReg[i] = '0;
        end
        expPc = pcResetValue;

        repeat (2) @(posedge Clock);
        @(negedge Clock);
        assert (step == stepT0 && !memWrite && memAddress == 8'h00) else stopWithFailure(
            $sformatf("ERR @%0t: in reset step %b write %b address %h",
                $time, step, memWrite, memAddress));
        @(posedge Clock);
        Reset <= 1'b0;  // Third edge with reset high
        @(negedge Clock);

        for (int i = 0; i < progLen; i++) begin
            runInstruction(progTable[i]);
        end

        for (int a = 0; a < 256; a++) begin
            assert (mem[a] == expMem[a]) else stopWithFailure(
                $sformatf("ERR @%0t: memory %h holds %h, expected %h",
                    $time, a, mem[a], expMem[a]));
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: build.f
cpuPkg.sv
controlBus.sv
instructionRegister.sv
controlUnit.sv
addressUnit.sv
dataUnit.sv
cpuSystem.sv
tbCpuSystem.sv

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tbCpuSystem -o simCpuSystem

# Exit status of the pipe is that of tee, the log decides the result
./obj_dir/simCpuSystem 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
